/* hw/mips_isa_pkg.sv */
package mips_isa_pkg;

	localparam int OPCODE_W = 6;
	localparam int FUNCT_W  = 6;

	// opcode field
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'b001000;
	localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'b001001;
	localparam logic [OPCODE_W-1:0] OP_BEQ   = 6'b000100;
	localparam logic [OPCODE_W-1:0] OP_BNE   = 6'b000101;
	localparam logic [OPCODE_W-1:0] OP_BLE   = 6'b000110;
	localparam logic [OPCODE_W-1:0] OP_BGT   = 6'b000111;
	localparam logic [OPCODE_W-1:0] OP_LUI   = 6'b001111;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'b100011;
	localparam logic [OPCODE_W-1:0] OP_SB    = 6'b101000;
	localparam logic [OPCODE_W-1:0] OP_SH    = 6'b101001;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'b101011;
	localparam logic [OPCODE_W-1:0] OP_J     = 6'b000010;
	localparam logic [OPCODE_W-1:0] OP_JAL   = 6'b000011;

	// funct field, R-type only
	localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
	localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
	localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
	localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
	localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
	localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
	localparam logic [FUNCT_W-1:0] FN_MULT = 6'b011000;
	localparam logic [FUNCT_W-1:0] FN_DIV  = 6'b011010;
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;

	typedef enum logic [4:0] {
		IC_ADD, IC_SUB, IC_AND, IC_SLT,
		IC_SHIFT_SHAMT, IC_SHIFT_REG,
		IC_ADDI, IC_ADDIU,
		IC_BRANCH_EQ, IC_BRANCH_GT, // beq/bne and ble/bgt
		IC_LOAD_WORD, IC_STORE,
		IC_JUMP, IC_JUMP_LINK, IC_JUMP_REG,
		IC_LUI, IC_MULT, IC_DIV,
		IC_ILLEGAL
	} instr_class_t;

endpackage

/* hw/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	typedef enum logic [2:0] {
		ALU_LOAD    = 3'b000,
		ALU_ADD     = 3'b001,
		ALU_SUB     = 3'b010,
		ALU_AND     = 3'b011,
		ALU_INC     = 3'b100,
		ALU_NOT     = 3'b101,
		ALU_XOR     = 3'b110,
		ALU_COMPARE = 3'b111
	} alu_op_t;

	typedef enum logic [2:0] {
		SH_NOP          = 3'b000,
		SH_LOAD_SRC     = 3'b001,
		SH_LEFT_ARITH   = 3'b010,
		SH_RIGHT_LOG    = 3'b011,
		SH_RIGHT_ARITH  = 3'b100,
		SH_ROTATE_RIGHT = 3'b101,
		SH_ROTATE_LEFT  = 3'b110
	} shift_op_t;

	typedef enum logic [1:0] {
		B_REG_B       = 2'b00,
		B_FOUR        = 2'b01,
		B_IMM         = 2'b10, // sign-extended
		B_IMM_SHIFTED = 2'b11  // branch offset
	} alu_b_src_t;

	typedef enum logic [1:0] {
		PC_ALU_RESULT = 2'b00,
		PC_ALU_OUT    = 2'b01,
		PC_JUMP       = 2'b10
	} pc_src_t;

	typedef enum logic [1:0] {
		ADDR_PC      = 2'b00,
		ADDR_ALU_OUT = 2'b01
	} addr_src_t;

	typedef enum logic [2:0] {
		WB_ALU_OUT    = 3'b000,
		WB_MEM        = 3'b001,
		WB_COMPARE    = 3'b100,
		WB_SHIFTER    = 3'b101,
		WB_LUI        = 3'b110,
		WB_STACK_INIT = 3'b111
	} wb_src_t;

	typedef enum logic [1:0] {
		DST_RT = 2'b00,
		DST_RA = 2'b01, // register 31
		DST_SP = 2'b10,
		DST_RD = 2'b11
	} reg_dst_t;

	typedef enum logic [1:0] {
		SIZE_NONE = 2'b00,
		SIZE_WORD = 2'b01,
		SIZE_HALF = 2'b10,
		SIZE_BYTE = 2'b11
	} mem_size_t;

	typedef enum logic [1:0] {
		SHAMT_REG_B = 2'b00,
		SHAMT_FIELD = 2'b10
	} shamt_src_t;

	typedef enum logic [5:0] {
		ST_STACK_INIT, ST_FETCH_1, ST_FETCH_2, ST_FETCH_3,
		ST_DECODE_1, ST_DECODE_2,
		ST_ADD, ST_SUB, ST_AND, ST_ARITH_WRITE, ST_SLT,
		ST_SHIFT_SHAMT, ST_SHIFT_REG,
		ST_SHIFT_LEFT, ST_SHIFT_RIGHT_LOG, ST_SHIFT_RIGHT_ARITH, ST_SHIFT_WRITE,
		ST_ADDI, ST_ADDI_WRITE,
		ST_BRANCH_1, ST_BRANCH_2,
		ST_MEM_ADDR_1, ST_MEM_ADDR_2, ST_MEM_ADDR_3,
		ST_SW, ST_SH, ST_SB, ST_LW,
		ST_JR, ST_JAL_1, ST_JAL_2, ST_JUMP, ST_LUI,
		ST_MULT_START, ST_MULT_WAIT, ST_MULT_WRITE,
		ST_DIV_START, ST_DIV_WAIT, ST_DIV_WRITE,
		ST_CLOSE
	} ctrl_state_t;

	// state and stack pointer setup applied out of reset
	localparam ctrl_state_t RESET_STATE  = ST_STACK_INIT;
	localparam wb_src_t     INIT_WB_SRC  = WB_STACK_INIT;
	localparam reg_dst_t    INIT_REG_DST = DST_SP;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic [mips_isa_pkg::OPCODE_W-1:0] i_op_code,
	input  logic [mips_isa_pkg::FUNCT_W-1:0]  i_funct,
	output mips_isa_pkg::instr_class_t        o_instr_class
);

	import mips_isa_pkg::*;

	instr_class_t rtype_class;

	// R-type ops are told apart by funct alone
	always_comb begin
		case (i_funct)
			FN_ADD: rtype_class = IC_ADD;
			FN_SUB: rtype_class = IC_SUB;
			FN_AND: rtype_class = IC_AND;
			FN_SLT: rtype_class = IC_SLT;
			FN_SLL,
			FN_SRL,
			FN_SRA: rtype_class = IC_SHIFT_SHAMT;
			FN_SLLV,
			FN_SRAV: rtype_class = IC_SHIFT_REG;
			FN_JR: rtype_class = IC_JUMP_REG;
			FN_MULT: rtype_class = IC_MULT;
			FN_DIV: rtype_class = IC_DIV;
			default: rtype_class = IC_ILLEGAL;
		endcase
	end

	always_comb begin
		case (i_op_code)
			OP_RTYPE: o_instr_class = rtype_class;
			OP_ADDI: o_instr_class = IC_ADDI;
			OP_ADDIU: o_instr_class = IC_ADDIU;
			OP_BEQ,
			OP_BNE: o_instr_class = IC_BRANCH_EQ;
			OP_BLE,
			OP_BGT: o_instr_class = IC_BRANCH_GT;
			OP_LW: o_instr_class = IC_LOAD_WORD;
			OP_SW,
			OP_SH,
			OP_SB: o_instr_class = IC_STORE; // size picked later from opcode
			OP_J: o_instr_class = IC_JUMP;
			OP_JAL: o_instr_class = IC_JUMP_LINK;
			OP_LUI: o_instr_class = IC_LUI;
			default: o_instr_class = IC_ILLEGAL;
		endcase
	end

endmodule

/* hw/ctrl_sequencer.sv */
`timescale 1ns/1ps

module ctrl_sequencer (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  mips_isa_pkg::instr_class_t        i_instr_class,
	input  logic [mips_isa_pkg::OPCODE_W-1:0] i_op_code,
	input  logic [mips_isa_pkg::FUNCT_W-1:0]  i_funct,
	input  logic                              i_equal,
	input  logic                              i_greater,
	input  logic                              i_mult_done,
	input  logic                              i_div_done,
	output mips_ctrl_pkg::ctrl_state_t        o_state,
	output logic                              o_branch_taken
);

	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	ctrl_state_t shift_op_state;
	ctrl_state_t store_state;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= RESET_STATE;
		end else begin
			state <= next_state;
		end
	end

	// beq/bne test equal, bgt/ble test greater
	always_comb begin
		case (i_op_code)
			OP_BEQ: o_branch_taken = i_equal;
			OP_BNE: o_branch_taken = !i_equal;
			OP_BGT: o_branch_taken = i_greater;
			OP_BLE: o_branch_taken = !i_greater;
			default: o_branch_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (i_funct)
			FN_SLL,
			FN_SLLV: shift_op_state = ST_SHIFT_LEFT;
			FN_SRL: shift_op_state = ST_SHIFT_RIGHT_LOG;
			default: shift_op_state = ST_SHIFT_RIGHT_ARITH; // sra, srav
		endcase
	end

	always_comb begin
		case (i_op_code)
			OP_SH: store_state = ST_SH;
			OP_SB: store_state = ST_SB;
			default: store_state = ST_SW;
		endcase
	end

	always_comb begin
		next_state = ST_CLOSE; // every last execute step closes
		case (state)
			ST_STACK_INIT: next_state = ST_FETCH_1;
			ST_FETCH_1: next_state = ST_FETCH_2;
			ST_FETCH_2: next_state = ST_FETCH_3;
			ST_FETCH_3: next_state = ST_DECODE_1;
			ST_DECODE_1: next_state = ST_DECODE_2;
			ST_DECODE_2: begin
				case (i_instr_class)
					IC_ADD: next_state = ST_ADD;
					IC_SUB: next_state = ST_SUB;
					IC_AND: next_state = ST_AND;
					IC_SLT: next_state = ST_SLT;
					IC_SHIFT_SHAMT: next_state = ST_SHIFT_SHAMT;
					IC_SHIFT_REG: next_state = ST_SHIFT_REG;
					IC_ADDI,
					IC_ADDIU: next_state = ST_ADDI;
					IC_BRANCH_EQ,
					IC_BRANCH_GT: next_state = ST_BRANCH_1;
					IC_LOAD_WORD,
					IC_STORE: next_state = ST_MEM_ADDR_1;
					IC_JUMP: next_state = ST_JUMP;
					IC_JUMP_LINK: next_state = ST_JAL_1;
					IC_JUMP_REG: next_state = ST_JR;
					IC_LUI: next_state = ST_LUI;
					IC_MULT: next_state = ST_MULT_START;
					IC_DIV: next_state = ST_DIV_START;
					default: next_state = ST_CLOSE;
				endcase
			end
			ST_ADD,
			ST_SUB,
			ST_AND: next_state = ST_ARITH_WRITE;
			ST_SHIFT_SHAMT,
			ST_SHIFT_REG: next_state = shift_op_state;
			ST_SHIFT_LEFT,
			ST_SHIFT_RIGHT_LOG,
			ST_SHIFT_RIGHT_ARITH: next_state = ST_SHIFT_WRITE;
			ST_ADDI: next_state = ST_ADDI_WRITE;
			ST_BRANCH_1: next_state = ST_BRANCH_2;
			ST_MEM_ADDR_1: next_state = ST_MEM_ADDR_2;
			ST_MEM_ADDR_2: next_state = ST_MEM_ADDR_3;
			ST_MEM_ADDR_3: next_state = (i_instr_class == IC_STORE) ? store_state : ST_LW;
			ST_JAL_1: next_state = ST_JAL_2;
			ST_JAL_2: next_state = ST_JUMP;
			ST_MULT_START: next_state = ST_MULT_WAIT;
			ST_MULT_WAIT: next_state = i_mult_done ? ST_MULT_WRITE : ST_MULT_WAIT;
			ST_DIV_START: next_state = ST_DIV_WAIT;
			ST_DIV_WAIT: next_state = i_div_done ? ST_DIV_WRITE : ST_DIV_WAIT;
			ST_CLOSE: next_state = ST_FETCH_1;
			default: next_state = ST_CLOSE;
		endcase
	end

	assign o_state = state;

endmodule

/* hw/ctrl_word_gen.sv */
`timescale 1ns/1ps

module ctrl_word_gen (
	input  mips_ctrl_pkg::ctrl_state_t i_state,
	input  logic                       i_branch_taken,
	output logic                       o_ir_write,
	output logic                       o_pc_write,
	output logic                       o_reg_write,
	output logic                       o_a_b_write,
	output logic                       o_memory_write,
	output logic                       o_mem_data_write,
	output logic                       o_alu_out_write,
	output logic                       o_alu_src_a,
	output mips_ctrl_pkg::addr_src_t   o_addr_src,
	output mips_ctrl_pkg::pc_src_t     o_pc_source,
	output mips_ctrl_pkg::alu_op_t     o_alu_op,
	output mips_ctrl_pkg::alu_b_src_t  o_alu_src_b,
	output mips_ctrl_pkg::wb_src_t     o_wb_src,
	output mips_ctrl_pkg::reg_dst_t    o_reg_dst,
	output mips_ctrl_pkg::shift_op_t   o_shift_op,
	output mips_ctrl_pkg::shamt_src_t  o_shamt_src,
	output mips_ctrl_pkg::mem_size_t   o_store_size,
	output logic                       o_mult_start,
	output logic                       o_div_start,
	output logic                       o_lo_write,
	output logic                       o_hi_write
);

	import mips_ctrl_pkg::*;

	always_comb begin
		// idle word, as in close
		o_ir_write       = 1'b0;
		o_pc_write       = 1'b0;
		o_reg_write      = 1'b0;
		o_a_b_write      = 1'b0;
		o_memory_write   = 1'b0;
		o_mem_data_write = 1'b0;
		o_alu_out_write  = 1'b0;
		o_alu_src_a      = 1'b0; // pc
		o_addr_src       = ADDR_PC;
		o_pc_source      = PC_ALU_RESULT;
		o_alu_op         = ALU_LOAD;
		o_alu_src_b      = B_REG_B;
		o_wb_src         = WB_ALU_OUT;
		o_reg_dst        = DST_RT;
		o_shift_op       = SH_NOP;
		o_shamt_src      = SHAMT_REG_B;
		o_store_size     = SIZE_NONE;
		o_mult_start     = 1'b0;
		o_div_start      = 1'b0;
		o_lo_write       = 1'b0;
		o_hi_write       = 1'b0;

		case (i_state)
			ST_STACK_INIT: begin
				o_reg_write = 1'b1;
				o_wb_src    = INIT_WB_SRC;
				o_reg_dst   = INIT_REG_DST;
			end
			ST_FETCH_1: begin
				o_alu_op    = ALU_ADD; // pc + 4
				o_alu_src_b = B_FOUR;
			end
			ST_FETCH_2: begin
				o_pc_write  = 1'b1;
				o_alu_op    = ALU_ADD;
				o_alu_src_b = B_FOUR;
			end
			ST_FETCH_3: o_ir_write = 1'b1;
			ST_DECODE_1: begin
				o_a_b_write     = 1'b1;
				o_alu_out_write = 1'b1; // branch target kept in alu out
				o_alu_src_b     = B_IMM_SHIFTED;
				o_alu_op        = ALU_ADD;
			end
			ST_ADD,
			ST_SUB,
			ST_AND: begin
				o_alu_src_a     = 1'b1;
				o_alu_out_write = 1'b1;
				o_alu_op        = (i_state == ST_ADD) ? ALU_ADD :
				                  (i_state == ST_SUB) ? ALU_SUB : ALU_AND;
			end
			ST_ARITH_WRITE,
			ST_ADDI_WRITE: begin
				o_reg_write = 1'b1;
				o_reg_dst   = (i_state == ST_ARITH_WRITE) ? DST_RD : DST_RT;
			end
			ST_SLT: begin
				o_alu_src_a = 1'b1;
				o_alu_op    = ALU_COMPARE;
				o_reg_write = 1'b1;
				o_reg_dst   = DST_RD;
				o_wb_src    = WB_COMPARE;
			end
			ST_SHIFT_SHAMT: begin
				o_shift_op  = SH_LOAD_SRC;
				o_shamt_src = SHAMT_FIELD;
			end
			ST_SHIFT_REG: o_shift_op = SH_LOAD_SRC; // amount from register b
			ST_SHIFT_LEFT: o_shift_op = SH_LEFT_ARITH;
			ST_SHIFT_RIGHT_LOG: o_shift_op = SH_RIGHT_LOG;
			ST_SHIFT_RIGHT_ARITH: o_shift_op = SH_RIGHT_ARITH;
			ST_SHIFT_WRITE: begin
				o_reg_write = 1'b1;
				o_reg_dst   = DST_RD;
				o_wb_src    = WB_SHIFTER;
			end
			ST_ADDI: begin
				o_alu_src_a     = 1'b1;
				o_alu_src_b     = B_IMM;
				o_alu_op        = ALU_ADD;
				o_alu_out_write = 1'b1;
			end
			ST_BRANCH_1,
			ST_BRANCH_2: begin
				o_alu_src_a = 1'b1;
				o_alu_op    = ALU_COMPARE;
				o_pc_source = PC_ALU_OUT;
				o_pc_write  = (i_state == ST_BRANCH_2) && i_branch_taken;
			end
			ST_MEM_ADDR_1,
			ST_MEM_ADDR_2,
			ST_MEM_ADDR_3: begin
				o_alu_src_a      = 1'b1; // base + offset
				o_alu_src_b      = B_IMM;
				o_alu_op         = ALU_ADD;
				o_addr_src       = ADDR_ALU_OUT;
				o_alu_out_write  = (i_state == ST_MEM_ADDR_1);
				o_mem_data_write = (i_state == ST_MEM_ADDR_3);
			end
			ST_SW,
			ST_SH,
			ST_SB: begin
				o_memory_write = 1'b1;
				o_addr_src     = ADDR_ALU_OUT;
				o_store_size   = (i_state == ST_SW) ? SIZE_WORD :
				                 (i_state == ST_SH) ? SIZE_HALF : SIZE_BYTE;
			end
			ST_LW: begin
				o_addr_src  = ADDR_ALU_OUT;
				o_reg_write = 1'b1;
				o_wb_src    = WB_MEM;
			end
			ST_JR: begin
				o_pc_write  = 1'b1;
				o_alu_src_a = 1'b1;
			end
			ST_JAL_1: o_alu_out_write = 1'b1; // return address
			ST_JAL_2: begin
				o_reg_write = 1'b1;
				o_reg_dst   = DST_RA;
			end
			ST_JUMP: begin
				o_pc_write  = 1'b1;
				o_pc_source = PC_JUMP;
			end
			ST_LUI: begin
				o_reg_write = 1'b1;
				o_wb_src    = WB_LUI;
			end
			ST_MULT_START: o_mult_start = 1'b1;
			ST_DIV_START: o_div_start = 1'b1;
			ST_MULT_WRITE,
			ST_DIV_WRITE: begin
				o_lo_write = 1'b1;
				o_hi_write = 1'b1;
			end
			default: ; // decode_2, waits and close stay idle
		endcase
	end

endmodule

/* hw/mips_ctrl_unit.sv */
`timescale 1ns/1ps

module mips_ctrl_unit (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic [mips_isa_pkg::OPCODE_W-1:0] i_op_code,
	input  logic [mips_isa_pkg::FUNCT_W-1:0]  i_funct,
	input  logic                              i_equal,
	input  logic                              i_greater,
	input  logic                              i_mult_done,
	input  logic                              i_div_done,
	output logic                              o_ir_write,
	output logic                              o_pc_write,
	output logic                              o_reg_write,
	output logic                              o_a_b_write,
	output logic                              o_memory_write,
	output logic                              o_mem_data_write,
	output logic                              o_alu_out_write,
	output logic                              o_alu_src_a,
	output mips_ctrl_pkg::addr_src_t          o_addr_src,
	output mips_ctrl_pkg::pc_src_t            o_pc_source,
	output mips_ctrl_pkg::alu_op_t            o_alu_op,
	output mips_ctrl_pkg::alu_b_src_t         o_alu_src_b,
	output mips_ctrl_pkg::wb_src_t            o_wb_src,
	output mips_ctrl_pkg::reg_dst_t           o_reg_dst,
	output mips_ctrl_pkg::shift_op_t          o_shift_op,
	output mips_ctrl_pkg::shamt_src_t         o_shamt_src,
	output mips_ctrl_pkg::mem_size_t          o_store_size,
	output logic                              o_mult_start,
	output logic                              o_div_start,
	output logic                              o_lo_write,
	output logic                              o_hi_write
);

	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	instr_class_t instr_class;
	ctrl_state_t  state;
	logic         branch_taken;

	instr_decoder instr_decoder_inst (
		.i_op_code     (i_op_code),
		.i_funct       (i_funct),
		.o_instr_class (instr_class)
	);

	ctrl_sequencer ctrl_sequencer_inst (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_instr_class  (instr_class),
		.i_op_code      (i_op_code),
		.i_funct        (i_funct),
		.i_equal        (i_equal),
		.i_greater      (i_greater),
		.i_mult_done    (i_mult_done),
		.i_div_done     (i_div_done),
		.o_state        (state),
		.o_branch_taken (branch_taken)
	);

	ctrl_word_gen ctrl_word_gen_inst (
		.i_state          (state),
		.i_branch_taken   (branch_taken),
		.o_ir_write       (o_ir_write),
		.o_pc_write       (o_pc_write),
		.o_reg_write      (o_reg_write),
		.o_a_b_write      (o_a_b_write),
		.o_memory_write   (o_memory_write),
		.o_mem_data_write (o_mem_data_write),
		.o_alu_out_write  (o_alu_out_write),
		.o_alu_src_a      (o_alu_src_a),
		.o_addr_src       (o_addr_src),
		.o_pc_source      (o_pc_source),
		.o_alu_op         (o_alu_op),
		.o_alu_src_b      (o_alu_src_b),
		.o_wb_src         (o_wb_src),
		.o_reg_dst        (o_reg_dst),
		.o_shift_op       (o_shift_op),
		.o_shamt_src      (o_shamt_src),
		.o_store_size     (o_store_size),
		.o_mult_start     (o_mult_start),
		.o_div_start      (o_div_start),
		.o_lo_write       (o_lo_write),
		.o_hi_write       (o_hi_write)
	);

endmodule

/* testbench/mips_ctrl_unit_sva.sv */
`timescale 1ns/1ps

module mips_ctrl_unit_sva (
	input logic i_clock,
	input logic i_reset,
	input logic i_mult_start,
	input logic i_div_start,
	input logic i_mult_done,
	input logic i_div_done,
	input logic i_lo_write,
	input logic i_ir_write,
	input logic i_a_b_write,
	input logic i_memory_write,
	input logic i_reg_write
);

	int fail_count = 0;

	mult_start_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mult_start |=> !i_mult_start)
		else begin
			fail_count++;
			$error("mult start held longer than one cycle");
		end

	div_start_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_div_start |=> !i_div_start)
		else begin
			fail_count++;
			$error("div start held longer than one cycle");
		end

	// result write only right after the unit reported done
	lo_write_after_done: assert property (@(posedge i_clock) disable iff (i_reset)
		i_lo_write |-> $past(i_mult_done || i_div_done))
		else begin
			fail_count++;
			$error("lo write without a done in the cycle before");
		end

	ir_then_operands: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ir_write |=> i_a_b_write)
		else begin
			fail_count++;
			$error("ir write not followed by a/b write");
		end

	no_mem_and_reg_write: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_memory_write && i_reg_write))
		else begin
			fail_count++;
			$error("memory write and register write in the same cycle");
		end

endmodule

/* testbench/mips_ctrl_unit_tb.sv */
`timescale 1ns/1ps

module mips_ctrl_unit_tb;

	import mips_isa_pkg::*;
	import mips_ctrl_pkg::*;

	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 16;
	localparam int MAX_DONE_DELAY = 12;
	localparam int INSTR_COUNT    = 32;
	localparam int INSTR_CYCLES   = 12; // fetch, decode, longest execute and close
	localparam int FETCH_TIMEOUT  = 16;
	localparam int TEST_CYCLES    = RESET_CYCLES + INSTR_COUNT * INSTR_CYCLES
	                                + 2 * MAX_DONE_DELAY;
	localparam int WATCHDOG_NS    = 2 * TEST_CYCLES * CLK_PERIOD;

	// one bit per write enable or strobe
	localparam logic [10:0] EN_NONE    = 11'd0;
	localparam logic [10:0] EN_IR      = 11'd1;
	localparam logic [10:0] EN_PC      = 11'd2;
	localparam logic [10:0] EN_REG     = 11'd4;
	localparam logic [10:0] EN_AB      = 11'd8;
	localparam logic [10:0] EN_MEM     = 11'd16;
	localparam logic [10:0] EN_MDR     = 11'd32;
	localparam logic [10:0] EN_ALU_OUT = 11'd64;
	localparam logic [10:0] EN_MSTART  = 11'd128;
	localparam logic [10:0] EN_DSTART  = 11'd256;
	localparam logic [10:0] EN_LO      = 11'd512;
	localparam logic [10:0] EN_HI      = 11'd1024;

	logic                clock;
	logic                reset;
	logic [OPCODE_W-1:0] op_code;
	logic [FUNCT_W-1:0]  funct;
	logic                equal;
	logic                greater;
	logic                mult_done;
	logic                div_done;
	logic                ir_write;
	logic                pc_write;
	logic                reg_write;
	logic                a_b_write;
	logic                memory_write;
	logic                mem_data_write;
	logic                alu_out_write;
	logic                alu_src_a;
	addr_src_t           addr_src;
	pc_src_t             pc_source;
	alu_op_t             alu_op;
	alu_b_src_t          alu_src_b;
	wb_src_t             wb_src;
	reg_dst_t            reg_dst;
	shift_op_t           shift_op;
	shamt_src_t          shamt_src;
	mem_size_t           store_size;
	logic                mult_start;
	logic                div_start;
	logic                lo_write;
	logic                hi_write;
	integer              seed;
	string               instr_name;
	string               step;

	mips_ctrl_unit mips_ctrl_unit_inst (
		.i_clock (clock), .i_reset (reset),
		.i_op_code (op_code), .i_funct (funct),
		.i_equal (equal), .i_greater (greater),
		.i_mult_done (mult_done), .i_div_done (div_done),
		.o_ir_write (ir_write), .o_pc_write (pc_write),
		.o_reg_write (reg_write), .o_a_b_write (a_b_write),
		.o_memory_write (memory_write), .o_mem_data_write (mem_data_write),
		.o_alu_out_write (alu_out_write), .o_alu_src_a (alu_src_a),
		.o_addr_src (addr_src), .o_pc_source (pc_source),
		.o_alu_op (alu_op), .o_alu_src_b (alu_src_b),
		.o_wb_src (wb_src), .o_reg_dst (reg_dst),
		.o_shift_op (shift_op), .o_shamt_src (shamt_src),
		.o_store_size (store_size),
		.o_mult_start (mult_start), .o_div_start (div_start),
		.o_lo_write (lo_write), .o_hi_write (hi_write)
	);

	bind mips_ctrl_unit mips_ctrl_unit_sva mips_ctrl_unit_sva_inst (
		.i_clock (i_clock), .i_reset (i_reset),
		.i_mult_start (o_mult_start), .i_div_start (o_div_start),
		.i_mult_done (i_mult_done), .i_div_done (i_div_done),
		.i_lo_write (o_lo_write), .i_ir_write (o_ir_write),
		.i_a_b_write (o_a_b_write), .i_memory_write (o_memory_write),
		.i_reg_write (o_reg_write)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_NS);
		report_failure("watchdog expired, the test sequence did not finish in time");
	end

	initial begin
		wait (mips_ctrl_unit_inst.mips_ctrl_unit_sva_inst.fail_count != 0);
		report_failure("a bound assertion failed, see the assertion message above");
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [7:0] got,
	                               input logic [7:0] exp);
		report_failure($sformatf("[ERROR] %s in %s: got 0x%0h, expected 0x%0h",
		                         sig, step, got, exp));
	endtask

	task automatic check_flag(input string sig, input logic got, input logic exp);
		if (got !== exp) report_mismatch(sig, got, exp);
	endtask

	task automatic check_alu_op(input alu_op_t got, input alu_op_t exp);
		if (got !== exp) report_mismatch("o_alu_op", got, exp);
	endtask

	task automatic check_alu_b_src(input alu_b_src_t got, input alu_b_src_t exp);
		if (got !== exp) report_mismatch("o_alu_src_b", got, exp);
	endtask

	task automatic check_pc_src(input pc_src_t got, input pc_src_t exp);
		if (got !== exp) report_mismatch("o_pc_source", got, exp);
	endtask

	task automatic check_addr_src(input addr_src_t got, input addr_src_t exp);
		if (got !== exp) report_mismatch("o_addr_src", got, exp);
	endtask

	task automatic check_wb_src(input wb_src_t got, input wb_src_t exp);
		if (got !== exp) report_mismatch("o_wb_src", got, exp);
	endtask

	task automatic check_reg_dst(input reg_dst_t got, input reg_dst_t exp);
		if (got !== exp) report_mismatch("o_reg_dst", got, exp);
	endtask

	task automatic check_shift_op(input shift_op_t got, input shift_op_t exp);
		if (got !== exp) report_mismatch("o_shift_op", got, exp);
	endtask

	task automatic check_shamt_src(input shamt_src_t got, input shamt_src_t exp);
		if (got !== exp) report_mismatch("o_shamt_src", got, exp);
	endtask

	task automatic check_mem_size(input mem_size_t got, input mem_size_t exp);
		if (got !== exp) report_mismatch("o_store_size", got, exp);
	endtask

	task automatic check_enables(input logic [10:0] mask);
		check_flag("o_ir_write", ir_write, mask[0]);
		check_flag("o_pc_write", pc_write, mask[1]);
		check_flag("o_reg_write", reg_write, mask[2]);
		check_flag("o_a_b_write", a_b_write, mask[3]);
		check_flag("o_memory_write", memory_write, mask[4]);
		check_flag("o_mem_data_write", mem_data_write, mask[5]);
		check_flag("o_alu_out_write", alu_out_write, mask[6]);
		check_flag("o_mult_start", mult_start, mask[7]);
		check_flag("o_div_start", div_start, mask[8]);
		check_flag("o_lo_write", lo_write, mask[9]);
		check_flag("o_hi_write", hi_write, mask[10]);
	endtask

	task automatic next_cycle;
		@(posedge clock);
		#1; // inputs change here
	endtask

	task automatic settle;
		@(negedge clock); // outputs sampled mid cycle
	endtask

	task automatic check_step(input string name, input logic [10:0] mask);
		settle();
		step = {instr_name, " ", name};
		check_enables(mask);
	endtask

	task automatic exec_step(input string name, input logic [10:0] mask);
		next_cycle();
		check_step(name, mask);
	endtask

	task automatic wait_fetch_3;
		int waited;
		waited = 0;
		while (ir_write !== 1'b1) begin
			if (waited >= FETCH_TIMEOUT) begin
				report_failure("no instruction fetch seen, the FSM did not return to fetch");
			end else begin
				next_cycle();
				settle();
				waited++;
			end
		end
	endtask

	task automatic begin_instr(input string name, input logic [OPCODE_W-1:0] op,
	                           input logic [FUNCT_W-1:0] fn);
		wait_fetch_3();
		instr_name = name;
		next_cycle();
		op_code = op;
		funct   = fn;
		check_step("decode_1", EN_AB | EN_ALU_OUT);
		check_alu_op(alu_op, ALU_ADD);
		check_alu_b_src(alu_src_b, B_IMM_SHIFTED);
		exec_step("decode_2", EN_NONE);
	endtask

	task automatic end_instr;
		exec_step("close", EN_NONE);
		exec_step("fetch_1", EN_NONE);
		check_alu_op(alu_op, ALU_ADD);
		check_alu_b_src(alu_src_b, B_FOUR);
	endtask

	// beq/bne look at equal, bgt/ble at greater
	function automatic logic branch_expected(input logic [OPCODE_W-1:0] op,
	                                         input logic eq, input logic gt);
		case (op)
			OP_BEQ: return eq;
			OP_BNE: return !eq;
			OP_BGT: return gt;
			default: return !gt;
		endcase
	endfunction

	task automatic test_reset;
		instr_name = "reset";
		check_step("stack_init", EN_REG);
		check_wb_src(wb_src, WB_STACK_INIT);
		check_reg_dst(reg_dst, DST_SP);
		exec_step("fetch_1", EN_NONE);
		check_alu_op(alu_op, ALU_ADD);
		check_alu_b_src(alu_src_b, B_FOUR);
		exec_step("fetch_2", EN_PC);
		check_alu_op(alu_op, ALU_ADD);
		check_alu_b_src(alu_src_b, B_FOUR);
		exec_step("fetch_3", EN_IR);
	endtask

	task automatic test_arith(input string name, input logic [FUNCT_W-1:0] fn,
	                          input alu_op_t op);
		begin_instr(name, OP_RTYPE, fn);
		exec_step("execute", EN_ALU_OUT);
		check_alu_op(alu_op, op);
		check_flag("o_alu_src_a", alu_src_a, 1'b1);
		exec_step("write", EN_REG);
		check_reg_dst(reg_dst, DST_RD);
		check_wb_src(wb_src, WB_ALU_OUT);
		end_instr();
	endtask

	task automatic test_slt;
		begin_instr("slt", OP_RTYPE, FN_SLT);
		exec_step("execute", EN_REG);
		check_alu_op(alu_op, ALU_COMPARE);
		check_reg_dst(reg_dst, DST_RD);
		check_wb_src(wb_src, WB_COMPARE);
		end_instr();
	endtask

	task automatic test_addi(input string name, input logic [OPCODE_W-1:0] op);
		begin_instr(name, op, 6'd0);
		exec_step("execute", EN_ALU_OUT);
		check_alu_op(alu_op, ALU_ADD);
		check_alu_b_src(alu_src_b, B_IMM);
		exec_step("write", EN_REG);
		check_reg_dst(reg_dst, DST_RT);
		check_wb_src(wb_src, WB_ALU_OUT);
		end_instr();
	endtask

	task automatic test_lui;
		begin_instr("lui", OP_LUI, 6'd0);
		exec_step("execute", EN_REG);
		check_reg_dst(reg_dst, DST_RT);
		check_wb_src(wb_src, WB_LUI);
		end_instr();
	endtask

	task automatic test_shift(input string name, input logic [FUNCT_W-1:0] fn,
	                          input shamt_src_t amount, input shift_op_t op);
		begin_instr(name, OP_RTYPE, fn);
		exec_step("shift load", EN_NONE);
		check_shift_op(shift_op, SH_LOAD_SRC);
		check_shamt_src(shamt_src, amount);
		exec_step("shift op", EN_NONE);
		check_shift_op(shift_op, op);
		exec_step("shift write", EN_REG);
		check_reg_dst(reg_dst, DST_RD);
		check_wb_src(wb_src, WB_SHIFTER);
		end_instr();
	endtask

	task automatic test_branch(input string name, input logic [OPCODE_W-1:0] op);
		logic eq;
		logic gt;
		logic taken;
		eq    = 1'($random(seed));
		gt    = 1'($random(seed));
		taken = branch_expected(op, eq, gt);
		begin_instr(name, op, 6'd0);
		next_cycle();
		equal   = eq;
		greater = gt;
		check_step("branch_1", EN_NONE);
		check_alu_op(alu_op, ALU_COMPARE);
		check_pc_src(pc_source, PC_ALU_OUT);
		exec_step("branch_2", taken ? EN_PC : EN_NONE);
		check_alu_op(alu_op, ALU_COMPARE);
		check_pc_src(pc_source, PC_ALU_OUT);
		end_instr();
	endtask

	task automatic address_steps;
		exec_step("addr_1", EN_ALU_OUT);
		check_addr_src(addr_src, ADDR_ALU_OUT);
		exec_step("addr_2", EN_NONE);
		check_addr_src(addr_src, ADDR_ALU_OUT);
		exec_step("addr_3", EN_MDR);
		check_addr_src(addr_src, ADDR_ALU_OUT);
	endtask

	task automatic test_store(input string name, input logic [OPCODE_W-1:0] op,
	                          input mem_size_t size);
		begin_instr(name, op, 6'd0);
		address_steps();
		exec_step("store", EN_MEM);
		check_mem_size(store_size, size);
		check_addr_src(addr_src, ADDR_ALU_OUT);
		end_instr();
	endtask

	task automatic test_lw;
		begin_instr("lw", OP_LW, 6'd0);
		address_steps();
		exec_step("load write", EN_REG);
		check_reg_dst(reg_dst, DST_RT);
		check_wb_src(wb_src, WB_MEM);
		end_instr();
	endtask

	task automatic test_jumps;
		begin_instr("j", OP_J, 6'd0);
		exec_step("jump", EN_PC);
		check_pc_src(pc_source, PC_JUMP);
		end_instr();
		begin_instr("jal", OP_JAL, 6'd0);
		exec_step("link", EN_ALU_OUT);
		exec_step("link write", EN_REG);
		check_reg_dst(reg_dst, DST_RA);
		exec_step("jump", EN_PC);
		check_pc_src(pc_source, PC_JUMP);
		end_instr();
		begin_instr("jr", OP_RTYPE, FN_JR);
		exec_step("jump", EN_PC);
		check_pc_src(pc_source, PC_ALU_RESULT);
		check_flag("o_alu_src_a", alu_src_a, 1'b1);
		end_instr();
	endtask

	task automatic test_mult_div(input bit is_div);
		int delay;
		int i;
		delay = 1 + ($unsigned($random(seed)) % MAX_DONE_DELAY);
		begin_instr(is_div ? "div" : "mult", OP_RTYPE, is_div ? FN_DIV : FN_MULT);
		exec_step("start", is_div ? EN_DSTART : EN_MSTART);
		for (i = 0; i < delay; i++) begin
			next_cycle();
			if (is_div) begin
				div_done = (i == delay - 1);
			end else begin
				mult_done = (i == delay - 1);
			end
			check_step("wait", EN_NONE);
		end
		next_cycle();
		mult_done = 1'b0;
		div_done  = 1'b0;
		check_step("write", EN_LO | EN_HI);
		end_instr();
	endtask

	task automatic test_illegal(input string name, input logic [OPCODE_W-1:0] op,
	                            input logic [FUNCT_W-1:0] fn);
		begin_instr(name, op, fn);
		end_instr(); // straight from decode_2 to close
	endtask

	initial begin
		seed       = 61202;
		instr_name = "reset";
		step       = "reset";
		reset      = 1'b1;
		op_code    = OP_RTYPE;
		funct      = FN_SLL;
		equal      = 1'b0;
		greater    = 1'b0;
		mult_done  = 1'b0;
		div_done   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;

		test_reset();
		test_arith("add", FN_ADD, ALU_ADD);
		test_arith("sub", FN_SUB, ALU_SUB);
		test_arith("and", FN_AND, ALU_AND);
		test_slt();
		test_addi("addi", OP_ADDI);
		test_addi("addiu", OP_ADDIU);
		test_lui();
		test_shift("sll", FN_SLL, SHAMT_FIELD, SH_LEFT_ARITH);
		test_shift("srl", FN_SRL, SHAMT_FIELD, SH_RIGHT_LOG);
		test_shift("sra", FN_SRA, SHAMT_FIELD, SH_RIGHT_ARITH);
		test_shift("sllv", FN_SLLV, SHAMT_REG_B, SH_LEFT_ARITH);
		test_shift("srav", FN_SRAV, SHAMT_REG_B, SH_RIGHT_ARITH);
		repeat (2) begin
			test_branch("beq", OP_BEQ);
			test_branch("bne", OP_BNE);
			test_branch("ble", OP_BLE);
			test_branch("bgt", OP_BGT);
		end
		test_store("sw", OP_SW, SIZE_WORD);
		test_store("sh", OP_SH, SIZE_HALF);
		test_store("sb", OP_SB, SIZE_BYTE);
		test_lw();
		test_jumps();
		test_mult_div(1'b0);
		test_mult_div(1'b1);
		test_illegal("bad opcode", 6'b111111, 6'd0);
		test_illegal("bad funct", OP_RTYPE, 6'b111111);

		repeat (2) @(posedge clock); // let the last assertions sample
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* mips_ctrl_unit.f */
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/instr_decoder.sv
hw/ctrl_sequencer.sv
hw/ctrl_word_gen.sv
hw/mips_ctrl_unit.sv
testbench/mips_ctrl_unit_sva.sv
testbench/mips_ctrl_unit_tb.sv
